// ==== rtl/sdmacRegPkg.sv ====
package sdmacRegPkg;

    // Bus data width
    localparam int DATA_W = 32;

    // Register word index taken from ADDR[6:2]
    typedef enum logic [4:0] {
        CNTR   = 5'h02,   // Control, byte 0x08
        ACR    = 5'h03,   // Address counter, byte 0x0C
        ST_DMA = 5'h04,   // Start DMA strobe
        FLUSH  = 5'h05,   // Flush partial longword
        CINT   = 5'h06,   // Clear latched interrupt
        ISTR   = 5'h07,   // Status
        SP_DMA = 5'h0F    // Stop DMA strobe
    } regAddrE;

    // CNTR bit positions
    localparam int CNTR_DMADIR = 1;   // Set for memory to SCSI
    localparam int CNTR_INTENA = 2;

    // ISTR bit positions
    localparam int ISTR_INT   = 0;    // Interrupt pending
    localparam int ISTR_FE    = 1;    // FIFO empty
    localparam int ISTR_FF    = 2;    // FIFO full
    localparam int ISTR_DMAON = 3;

endpackage

// ==== rtl/sdmacBusPkg.sv ====
package sdmacBusPkg;

    // Transfer direction, as held in CNTR
    typedef enum logic {
        SCSI_TO_MEM = 1'b0,
        MEM_TO_SCSI = 1'b1
    } dmaDirE;

    // SCSI byte cycle: two strobe cycles and one recover cycle
    typedef enum logic [1:0] {
        S_IDLE,
        S_STROBE1,
        S_STROBE2,
        S_RECOVER
    } scsiStateE;

    // Bus master sequence
    typedef enum logic [2:0] {
        M_IDLE,
        M_REQ,       // Bus requested, waiting for grant
        M_CYCLE,     // Longword cycle in progress
        M_WAIT,      // FIFO and counter settle after the ack
        M_RELEASE
    } masterStateE;

endpackage

// ==== rtl/dmaRegisters.sv ====
`timescale 1ns/1ps

module dmaRegisters (
    input  logic                             QnCPUCLK,
    input  logic                             rstN_i,
    input  logic                             regWr_i,
    input  logic                             regRd_i,
    input  sdmacRegPkg::regAddrE             regAddr_i,
    input  logic [sdmacRegPkg::DATA_W-1:0]   regWdata_i,
    input  logic                             fifoEmpty_i,
    input  logic                             fifoFull_i,
    input  logic                             intA_i,
    input  logic                             acrInc_i,
    output logic [sdmacRegPkg::DATA_W-1:0]   regRdata_o,
    output logic                             regAck_o,
    output sdmacBusPkg::dmaDirE              dmaDir_o,
    output logic                             dmaEna_o,
    output logic                             flushReq_o,
    output logic [sdmacRegPkg::DATA_W-1:0]   acr_o,
    output logic                             intN_o
);
    import sdmacRegPkg::*;
    import sdmacBusPkg::*;

    logic [7:0]        cntrReg;
    logic [DATA_W-1:0] acrReg;
    logic              dmaEnaReg;
    logic              intPend;      // Latched on rising edge of INTA
    logic              intAD;        // INTA delayed for edge detect
    logic [DATA_W-1:0] istrVal;
    logic [DATA_W-1:0] rdMux;

    always_comb begin
        istrVal             = '0;
        istrVal[ISTR_INT]   = intPend;
        istrVal[ISTR_FE]    = fifoEmpty_i;
        istrVal[ISTR_FF]    = fifoFull_i;
        istrVal[ISTR_DMAON] = dmaEnaReg;
    end

    always_comb begin
        case (regAddr_i)
            CNTR:    rdMux = {{(DATA_W-8){1'b0}}, cntrReg};
            ACR:     rdMux = acrReg;
            ISTR:    rdMux = istrVal;
            default: rdMux = '0;   // Command strobes read as zero
        endcase
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            cntrReg    <= '0;
            acrReg     <= '0;
            dmaEnaReg  <= 1'b0;
            intPend    <= 1'b0;
            intAD      <= 1'b0;
            flushReq_o <= 1'b0;
            regAck_o   <= 1'b0;
        end else begin
            regAck_o   <= regWr_i | regRd_i;
            flushReq_o <= regWr_i && (regAddr_i == FLUSH);
            intAD      <= intA_i;

            if (intA_i && !intAD)
                intPend <= 1'b1;
            else if (regWr_i && (regAddr_i == CINT))
                intPend <= 1'b0;

            if (acrInc_i)
                acrReg <= acrReg + 32'd4;   // Next longword

            if (regWr_i) begin
                case (regAddr_i)
                    CNTR:    cntrReg   <= regWdata_i[7:0];
                    ACR:     acrReg    <= {regWdata_i[DATA_W-1:2], 2'b00};
                    ST_DMA:  dmaEnaReg <= 1'b1;
                    SP_DMA:  dmaEnaReg <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Read data registered alongside the ack
    always_ff @(posedge QnCPUCLK) begin
        if (regRd_i)
            regRdata_o <= rdMux;
    end

    assign dmaDir_o = dmaDirE'(cntrReg[CNTR_DMADIR]);
    assign dmaEna_o = dmaEnaReg;
    assign acr_o    = acrReg;
    assign intN_o   = ~(intA_i & cntrReg[CNTR_INTENA]);

    aRegStrobeExcl: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(regWr_i && regRd_i));

endmodule

// ==== rtl/dmaFifo.sv ====
`timescale 1ns/1ps

module dmaFifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  sdmacBusPkg::dmaDirE  dmaDir_i,
    input  logic                 byteIn_i,
    input  logic [7:0]           pd_i,
    input  logic                 byteTaken_i,
    input  logic                 flushReq_i,
    input  logic                 wordPush_i,
    input  logic                 wordPop_i,
    input  logic [31:0]          memRdata_i,
    output logic [7:0]           byteOut_o,
    output logic                 byteAvail_o,
    output logic                 byteSpace_o,
    output logic                 wordAvail_o,
    output logic                 wordSpace_o,
    output logic [31:0]          wordOut_o,
    output logic                 fifoEmpty_o,
    output logic                 fifoFull_o
);
    import sdmacBusPkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [31:0] mem [FIFO_DEPTH];
    logic [AW:0] wrPtr;            // Extra bit tells full from empty
    logic [AW:0] rdPtr;
    logic [1:0]  byteOff;          // Byte lane, 0 is bits 31:24
    logic [4:0]  laneSel;
    logic [31:0] packReg;
    logic [31:0] packNext;
    logic [31:0] flushMask;
    logic [31:0] memWrData;
    logic        packCommit;
    logic        flushClr;
    logic        flushCommit;
    logic        lastByteTaken;
    logic        memWrEn;

    assign laneSel   = {~byteOff, 3'b000};   // 8 * (3 - byteOff)
    assign flushMask = ~(32'hFFFF_FFFF >> {byteOff, 3'b000});

    always_comb begin
        packNext                = packReg;
        packNext[laneSel +: 8]  = pd_i;
    end

    assign packCommit    = byteIn_i && (byteOff == 2'd3);
    assign flushClr      = flushReq_i && (dmaDir_i == SCSI_TO_MEM) && !byteIn_i;
    assign flushCommit   = flushClr && (byteOff != 2'd0);   // Nothing to commit when empty
    assign lastByteTaken = byteTaken_i && (byteOff == 2'd3);
    assign memWrEn       = wordPush_i | packCommit | flushCommit;

    always_comb begin
        if (wordPush_i)
            memWrData = memRdata_i;
        else if (packCommit)
            memWrData = packNext;
        else
            memWrData = packReg & flushMask;   // Low lanes padded with zero
    end

    always_ff @(posedge QnCPUCLK) begin
        if (memWrEn)
            mem[wrPtr[AW-1:0]] <= memWrData;
        if (byteIn_i)
            packReg <= packNext;
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            byteOff <= '0;
        end else begin
            if (memWrEn)
                wrPtr <= wrPtr + 1'b1;
            if (wordPop_i || lastByteTaken)
                rdPtr <= rdPtr + 1'b1;
            if (byteIn_i || byteTaken_i)
                byteOff <= byteOff + 1'b1;   // Wraps at the longword boundary
            else if (flushClr)
                byteOff <= '0;
        end
    end

    assign fifoEmpty_o = (wrPtr == rdPtr);
    assign fifoFull_o  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);

    assign wordOut_o   = mem[rdPtr[AW-1:0]];
    assign byteOut_o   = wordOut_o[laneSel +: 8];   // MSB first
    assign wordAvail_o = !fifoEmpty_o;
    assign wordSpace_o = !fifoFull_o;
    assign byteSpace_o = (dmaDir_i == SCSI_TO_MEM) && !fifoFull_o;
    assign byteAvail_o = (dmaDir_i == MEM_TO_SCSI) && !fifoEmpty_o;

    aFifoBounds: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(memWrEn && fifoFull_o) && !(wordPop_i && fifoEmpty_o));

endmodule

// ==== rtl/scsiPortSm.sv ====
`timescale 1ns/1ps

module scsiPortSm (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  logic                 dmaEna_i,
    input  sdmacBusPkg::dmaDirE  dmaDir_i,
    input  logic                 dreqN_i,
    input  logic                 byteSpace_i,
    input  logic                 byteAvail_i,
    output logic                 dackN_o,
    output logic                 iorN_o,
    output logic                 iowN_o,
    output logic                 byteIn_o,
    output logic                 byteTaken_o
);
    import sdmacBusPkg::*;

    scsiStateE state;
    scsiStateE nextState;
    dmaDirE    cycDir;        // Direction fixed for the whole byte cycle
    logic      startOk;
    logic      strobeOn;

    assign startOk = dmaEna_i && !dreqN_i &&
                     ((dmaDir_i == SCSI_TO_MEM) ? byteSpace_i : byteAvail_i);

    always_comb begin
        nextState = state;
        case (state)
            S_IDLE:    if (startOk) nextState = S_STROBE1;
            S_STROBE1: nextState = S_STROBE2;
            S_STROBE2: nextState = S_RECOVER;
            S_RECOVER: nextState = startOk ? S_STROBE1 : S_IDLE;   // Back to back bytes
            default:   nextState = S_IDLE;
        endcase
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state  <= S_IDLE;
            cycDir <= SCSI_TO_MEM;
        end else begin
            state <= nextState;
            if (nextState == S_STROBE1)
                cycDir <= dmaDir_i;
        end
    end

    assign strobeOn = (state == S_STROBE1) || (state == S_STROBE2);

    assign dackN_o = !strobeOn;
    assign iorN_o  = !(strobeOn && (cycDir == SCSI_TO_MEM));   // Chip read
    assign iowN_o  = !(strobeOn && (cycDir == MEM_TO_SCSI));

    // FIFO strobes at the end of the second strobe cycle
    assign byteIn_o    = (state == S_STROBE2) && (cycDir == SCSI_TO_MEM);
    assign byteTaken_o = (state == S_STROBE2) && (cycDir == MEM_TO_SCSI);

    aStrobeExcl: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(!iorN_o && !iowN_o));

endmodule

// ==== rtl/cpuBusMaster.sv ====
`timescale 1ns/1ps

module cpuBusMaster (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  logic                 dmaEna_i,
    input  sdmacBusPkg::dmaDirE  dmaDir_i,
    input  logic [31:0]          acr_i,
    input  logic                 wordAvail_i,
    input  logic                 wordSpace_i,
    input  logic [31:0]          wordOut_i,
    input  logic                 busGrant_i,
    input  logic                 memAck_i,
    output logic                 busReq_o,
    output logic                 own_o,
    output logic                 memReq_o,
    output logic                 memWe_o,
    output logic [31:0]          memAddr_o,
    output logic [31:0]          memWdata_o,
    output logic                 wordPush_o,
    output logic                 wordPop_o,
    output logic                 acrInc_o
);
    import sdmacBusPkg::*;

    masterStateE state;
    masterStateE nextState;
    logic        work;
    logic        ackCycle;

    // A word to write out, or room for one coming in
    assign work     = dmaEna_i && ((dmaDir_i == SCSI_TO_MEM) ? wordAvail_i : wordSpace_i);
    assign ackCycle = (state == M_CYCLE) && memAck_i;

    always_comb begin
        nextState = state;
        case (state)
            M_IDLE:    if (work) nextState = M_REQ;
            M_REQ: begin
                if (!dmaEna_i)
                    nextState = M_RELEASE;
                else if (busGrant_i)
                    nextState = M_CYCLE;
            end
            M_CYCLE:   if (memAck_i) nextState = M_WAIT;   // SP_DMA waits for the ack
            M_WAIT:    nextState = work ? M_CYCLE : M_RELEASE;
            M_RELEASE: nextState = M_IDLE;
            default:   nextState = M_IDLE;
        endcase
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i)
            state <= M_IDLE;
        else
            state <= nextState;
    end

    assign own_o    = (state == M_CYCLE) || (state == M_WAIT);
    assign busReq_o = (state == M_REQ) || own_o;
    assign memReq_o = (state == M_CYCLE);
    assign memWe_o  = memReq_o && (dmaDir_i == SCSI_TO_MEM);

    // Address and data stay put until the ack moves the counter and FIFO
    assign memAddr_o  = acr_i;
    assign memWdata_o = wordOut_i;

    assign wordPop_o  = ackCycle && (dmaDir_i == SCSI_TO_MEM);
    assign wordPush_o = ackCycle && (dmaDir_i == MEM_TO_SCSI);
    assign acrInc_o   = ackCycle;

    aReqOwned: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        memReq_o |-> own_o);

    aReqHeld: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        memReq_o && !memAck_i |=> memReq_o && $stable(memAddr_o));

endmodule

// ==== rtl/resdmacTop.sv ====
`timescale 1ns/1ps

module resdmacTop #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                             QnCPUCLK,
    input  logic                             rstN_i,
    input  logic                             regWr_i,
    input  logic                             regRd_i,
    input  sdmacRegPkg::regAddrE             regAddr_i,
    input  logic [sdmacRegPkg::DATA_W-1:0]   regWdata_i,
    input  logic                             dreqN_i,
    input  logic [7:0]                       pd_i,
    input  logic                             intA_i,
    input  logic                             busGrant_i,
    input  logic                             memAck_i,
    input  logic [31:0]                      memRdata_i,
    output logic [sdmacRegPkg::DATA_W-1:0]   regRdata_o,
    output logic                             regAck_o,
    output logic                             dackN_o,
    output logic                             iorN_o,
    output logic                             iowN_o,
    output logic [7:0]                       pd_o,
    output logic                             intN_o,
    output logic                             busReq_o,
    output logic                             own_o,
    output logic                             memReq_o,
    output logic                             memWe_o,
    output logic [31:0]                      memAddr_o,
    output logic [31:0]                      memWdata_o
);
    import sdmacBusPkg::*;

    dmaDirE      dmaDir;
    logic        dmaEna, flushReq, acrInc;
    logic [31:0] acr;
    logic [31:0] wordOut;
    logic        fifoEmpty, fifoFull;
    logic        byteIn, byteTaken, byteAvail, byteSpace;   // SCSI side of the FIFO
    logic        wordAvail, wordSpace, wordPush, wordPop;   // Memory side

    dmaRegisters dmaRegisters_inst (
        .QnCPUCLK   (QnCPUCLK),   .rstN_i     (rstN_i),
        .regWr_i    (regWr_i),    .regRd_i    (regRd_i),
        .regAddr_i  (regAddr_i),  .regWdata_i (regWdata_i),
        .fifoEmpty_i(fifoEmpty),  .fifoFull_i (fifoFull),
        .intA_i     (intA_i),     .acrInc_i   (acrInc),
        .regRdata_o (regRdata_o), .regAck_o   (regAck_o),
        .dmaDir_o   (dmaDir),     .dmaEna_o   (dmaEna),
        .flushReq_o (flushReq),   .acr_o      (acr),
        .intN_o     (intN_o)
    );

    dmaFifo #(.FIFO_DEPTH(FIFO_DEPTH)) dmaFifo_inst (
        .QnCPUCLK   (QnCPUCLK),   .rstN_i     (rstN_i),
        .dmaDir_i   (dmaDir),     .byteIn_i   (byteIn),
        .pd_i       (pd_i),       .byteTaken_i(byteTaken),
        .flushReq_i (flushReq),   .wordPush_i (wordPush),
        .wordPop_i  (wordPop),    .memRdata_i (memRdata_i),
        .byteOut_o  (pd_o),       .byteAvail_o(byteAvail),
        .byteSpace_o(byteSpace),  .wordAvail_o(wordAvail),
        .wordSpace_o(wordSpace),  .wordOut_o  (wordOut),
        .fifoEmpty_o(fifoEmpty),  .fifoFull_o (fifoFull)
    );

    scsiPortSm scsiPortSm_inst (
        .QnCPUCLK   (QnCPUCLK),   .rstN_i     (rstN_i),
        .dmaEna_i   (dmaEna),     .dmaDir_i   (dmaDir),
        .dreqN_i    (dreqN_i),    .byteSpace_i(byteSpace),
        .byteAvail_i(byteAvail),  .dackN_o    (dackN_o),
        .iorN_o     (iorN_o),     .iowN_o     (iowN_o),
        .byteIn_o   (byteIn),     .byteTaken_o(byteTaken)
    );

    cpuBusMaster cpuBusMaster_inst (
        .QnCPUCLK   (QnCPUCLK),   .rstN_i     (rstN_i),
        .dmaEna_i   (dmaEna),     .dmaDir_i   (dmaDir),
        .acr_i      (acr),        .wordAvail_i(wordAvail),
        .wordSpace_i(wordSpace),  .wordOut_i  (wordOut),
        .busGrant_i (busGrant_i), .memAck_i   (memAck_i),
        .busReq_o   (busReq_o),   .own_o      (own_o),
        .memReq_o   (memReq_o),   .memWe_o    (memWe_o),
        .memAddr_o  (memAddr_o),  .memWdata_o (memWdata_o),
        .wordPush_o (wordPush),   .wordPop_o  (wordPop),
        .acrInc_o   (acrInc)
    );

endmodule

// ==== bench/resdmacTests.svh ====
task automatic testResetRegs();
    logic [DATA_W-1:0] rd;
    curTest = "resetRegs";
    applyReset();
    checkBit("intN after reset", 1'b1, intN);
    checkBit("dackN after reset", 1'b1, dackN);
    checkBit("busReq after reset", 1'b0, busReq);
    readReg(ISTR, rd);
    checkBit("ISTR FE", 1'b1, rd[ISTR_FE]);
    checkBit("ISTR DMAON", 1'b0, rd[ISTR_DMAON]);
    writeReg(CNTR, 32'h0000_005A);
    readReg(CNTR, rd);
    checkReg(CNTR, 32'h0000_005A, rd);
    writeReg(ACR, 32'h1234_5678);
    readReg(ACR, rd);
    checkReg(ACR, 32'h1234_5678, rd);
endtask

task automatic testScsiToMem();
    logic [7:0]        bytes [8];
    logic [DATA_W-1:0] rd;
    int                i;
    curTest = "scsiToMem";
    applyReset();
    for (i = 0; i < 8; i++) begin
        bytes[i] = randomByte();
        txQ.push_back(bytes[i]);
    end
    writeReg(ACR, 32'h100);
    writeReg(CNTR, 32'h0);
    writeReg(ST_DMA, 32'h0);
    waitFor("writes", 2);
    waitFor("idle", 0);
    checkWord("write count", 2, wrAddrQ.size());
    checkWord("first address", 32'h100, wrAddrQ[0]);
    checkWord("first word", {bytes[0], bytes[1], bytes[2], bytes[3]}, wrDataQ[0]);
    checkWord("second address", 32'h104, wrAddrQ[1]);
    checkWord("second word", {bytes[4], bytes[5], bytes[6], bytes[7]}, wrDataQ[1]);
    readReg(ACR, rd);
    checkReg(ACR, 32'h108, rd);
endtask

task automatic testMemToScsi();
    logic [DATA_W-1:0] cntrVal;
    logic [31:0]       word;
    int                i;
    curTest = "memToScsi";
    applyReset();
    memArr[32'h200 >> 2] = randomWord();
    memArr[(32'h200 >> 2) + 1] = randomWord();
    rxWant = 8;
    cntrVal = '0;
    cntrVal[CNTR_DMADIR] = MEM_TO_SCSI;
    writeReg(ACR, 32'h200);
    writeReg(CNTR, cntrVal);
    writeReg(ST_DMA, 32'h0);
    waitFor("rx bytes", 8);
    for (i = 0; i < 8 && i < rxQ.size(); i++) begin
        word = memArr[(32'h200 >> 2) + i / 4];   // MSB of each longword goes out first
        checkWord($sformatf("byte %0d", i), {24'h0, word[8 * (3 - i % 4) +: 8]},
                  {24'h0, rxQ[i]});
    end
    checkWord("memory writes", 0, wrAddrQ.size());   // Reads only in this direction
    writeReg(SP_DMA, 32'h0);
endtask

task automatic testFlush();
    logic [7:0]        bytes [6];
    logic [DATA_W-1:0] rd;
    int                i;
    curTest = "flush";
    applyReset();
    for (i = 0; i < 6; i++) begin
        bytes[i] = randomByte();
        txQ.push_back(bytes[i]);
    end
    writeReg(ACR, 32'h180);
    writeReg(ST_DMA, 32'h0);
    waitFor("writes", 1);
    waitFor("idle", 0);
    writeReg(FLUSH, 32'h0);
    waitFor("writes", 2);
    waitFor("idle", 0);
    checkWord("full word", {bytes[0], bytes[1], bytes[2], bytes[3]}, wrDataQ[0]);
    checkWord("flush address", 32'h184, wrAddrQ[1]);
    checkWord("padded word", {bytes[4], bytes[5], 16'h0000}, wrDataQ[1]);
    readReg(ISTR, rd);
    checkBit("ISTR FE after flush", 1'b1, rd[ISTR_FE]);
endtask

task automatic testInterrupt();
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] cntrVal;
    curTest = "interrupt";
    applyReset();
    writeReg(CNTR, 32'h0);
    @(posedge QnCPUCLK);
    intA <= 1'b1;
    @(negedge QnCPUCLK);
    checkBit("intN masked", 1'b1, intN);
    @(posedge QnCPUCLK);
    intA <= 1'b0;
    readReg(ISTR, rd);
    checkBit("ISTR INT latched", 1'b1, rd[ISTR_INT]);
    writeReg(CINT, 32'h0);
    readReg(ISTR, rd);
    checkBit("ISTR INT cleared", 1'b0, rd[ISTR_INT]);
    cntrVal = '0;
    cntrVal[CNTR_INTENA] = 1'b1;
    writeReg(CNTR, cntrVal);
    @(posedge QnCPUCLK);
    intA <= 1'b1;
    @(negedge QnCPUCLK);
    checkBit("intN enabled", 1'b0, intN);
    @(posedge QnCPUCLK);
    intA <= 1'b0;
    @(negedge QnCPUCLK);
    checkBit("intN released", 1'b1, intN);
endtask

task automatic testArbitration();
    logic [7:0] bytes [4];
    int         i;
    curTest = "arbitration";
    applyReset();
    holdGrant = 1'b1;
    for (i = 0; i < 4; i++) begin
        bytes[i] = randomByte();
        txQ.push_back(bytes[i]);
    end
    writeReg(ACR, 32'h300);
    writeReg(ST_DMA, 32'h0);
    waitFor("bus request", 0);
    repeat (10) begin
        @(negedge QnCPUCLK);
        checkBit("memReq without grant", 1'b0, memReq);
        checkBit("own without grant", 1'b0, own);
    end
    holdGrant = 1'b0;
    waitFor("own", 0);
    checkBit("grant seen with own", 1'b1, busGrant);
    waitFor("writes", 1);
    checkWord("write address", 32'h300, wrAddrQ[0]);
    checkWord("write word", {bytes[0], bytes[1], bytes[2], bytes[3]}, wrDataQ[0]);
endtask

// ==== bench/resdmacTb.sv ====
`timescale 1ns/1ps

module resdmacTb;
    import sdmacRegPkg::*;
    import sdmacBusPkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int WAIT_LIMIT      = 300;   // Cycles before a wait gives up
    localparam int GRANT_DELAY     = 2;
    localparam int ACK_DELAY       = 2;

    logic              QnCPUCLK;
    logic              rstN     = 1'b0;
    logic              regWr    = 1'b0;
    logic              regRd    = 1'b0;
    regAddrE           regAddr  = CNTR;
    logic [DATA_W-1:0] regWdata = '0;
    logic              dreqN    = 1'b1;
    logic [7:0]        pdIn     = 8'h00;
    logic              intA     = 1'b0;
    logic              busGrant = 1'b0;
    logic              memAck   = 1'b0;
    logic [31:0]       memRdata = '0;
    logic [DATA_W-1:0] regRdata;
    logic              regAck, dackN, iorN, iowN, intN;
    logic              busReq, own, memReq, memWe;
    logic [7:0]        pdOut;
    logic [31:0]       memAddr, memWdata;

    integer      seed       = 62850;
    string       curTest    = "";
    int          errCount   = 0;
    int          checkCount = 0;
    bit          holdGrant  = 1'b0;   // Memory side withholds the grant
    int          rxWant     = 0;      // Bytes the SCSI chip still asks for
    int          grantCnt;
    int          ackCnt;
    logic        iorPrev;
    logic        iowPrev;
    logic [7:0]  txQ[$];
    logic [7:0]  rxQ[$];
    logic [31:0] wrAddrQ[$];
    logic [31:0] wrDataQ[$];
    logic [31:0] memArr [256];

    resdmacTop #(.FIFO_DEPTH(8)) resdmacTop_inst (
        .QnCPUCLK  (QnCPUCLK), .rstN_i     (rstN),
        .regWr_i   (regWr),    .regRd_i    (regRd),
        .regAddr_i (regAddr),  .regWdata_i (regWdata),
        .dreqN_i   (dreqN),    .pd_i       (pdIn),
        .intA_i    (intA),     .busGrant_i (busGrant),
        .memAck_i  (memAck),   .memRdata_i (memRdata),
        .regRdata_o(regRdata), .regAck_o   (regAck),
        .dackN_o   (dackN),    .iorN_o     (iorN),
        .iowN_o    (iowN),     .pd_o       (pdOut),
        .intN_o    (intN),     .busReq_o   (busReq),
        .own_o     (own),      .memReq_o   (memReq),
        .memWe_o   (memWe),    .memAddr_o  (memAddr),
        .memWdata_o(memWdata)
    );

    initial begin
        QnCPUCLK = 1'b0;
        forever #(CLK_PERIOD / 2) QnCPUCLK = ~QnCPUCLK;
    end

    // Memory and arbiter: grant and ack each come a fixed delay after the request
    always @(posedge QnCPUCLK or negedge rstN) begin
        if (!rstN) begin
            busGrant <= 1'b0;
            memAck   <= 1'b0;
            grantCnt = 0;
            ackCnt   = 0;
        end else begin
            memAck <= 1'b0;
            if (busReq && !holdGrant) begin
                if (grantCnt == GRANT_DELAY - 1)
                    busGrant <= 1'b1;
                else
                    grantCnt++;
            end else begin
                busGrant <= 1'b0;
                grantCnt = 0;
            end
            if (memReq && !memAck) begin
                if (ackCnt == ACK_DELAY - 1) begin
                    memAck   <= 1'b1;
                    memRdata <= memArr[memAddr[9:2]];
                    ackCnt   = 0;
                    if (memWe) begin
                        wrAddrQ.push_back(memAddr);
                        wrDataQ.push_back(memWdata);
                    end
                end else begin
                    ackCnt++;
                end
            end
        end
    end

    // SCSI chip: a byte moves at the clock edge that ends the second strobe cycle
    always @(posedge QnCPUCLK or negedge rstN) begin
        if (!rstN) begin
            dreqN   <= 1'b1;
            iorPrev = 1'b1;
            iowPrev = 1'b1;
        end else begin
            if (!iorN && !iorPrev && txQ.size() > 0)
                txQ.delete(0);
            if (!iowN && !iowPrev && rxWant > 0) begin
                rxQ.push_back(pdOut);
                rxWant--;
            end
            iorPrev = iorN;
            iowPrev = iowN;
            dreqN <= !(txQ.size() > 0 || rxWant > 0);
            if (txQ.size() > 0)
                pdIn <= txQ[0];
        end
    end

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hC3A5, addr[31:16] ^ addr[15:0]};
    endfunction

    function automatic logic [7:0] randomByte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    task automatic checkWord(input string what, input logic [DATA_W-1:0] expVal,
                             input logic [DATA_W-1:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("ERR %s %s: expected %h, actual %h", curTest, what, expVal, actVal);
        end
    endtask

    task automatic checkReg(input regAddrE addr, input logic [DATA_W-1:0] expVal,
                            input logic [DATA_W-1:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("ERR %s %s: expected %h, actual %h", curTest, addr.name(), expVal, actVal);
        end
    endtask

    task automatic checkBit(input string what, input logic expVal, input logic actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("ERR %s %s: expected %b, actual %b", curTest, what, expVal, actVal);
        end
    endtask

    // One strobe, ack expected exactly one cycle later
    task automatic regAccess(input logic isWrite, input regAddrE addr,
                             input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata);
        @(posedge QnCPUCLK);
        regWr    <= isWrite;
        regRd    <= !isWrite;
        regAddr  <= addr;
        regWdata <= data;
        @(negedge QnCPUCLK);
        checkBit("early ack", 1'b0, regAck);
        @(posedge QnCPUCLK);
        regWr <= 1'b0;
        regRd <= 1'b0;
        @(negedge QnCPUCLK);
        checkBit("ack", 1'b1, regAck);
        rdata = regRdata;
    endtask

    task automatic writeReg(input regAddrE addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] discard;
        regAccess(1'b1, addr, data, discard);
    endtask

    task automatic readReg(input regAddrE addr, output logic [DATA_W-1:0] data);
        regAccess(1'b0, addr, '0, data);
    endtask

    function automatic bit condMet(input string what, input int count);
        if (what == "writes")
            return wrAddrQ.size() >= count;
        if (what == "rx bytes")
            return rxQ.size() >= count;
        if (what == "idle")
            return !busReq && dackN && txQ.size() == 0;
        if (what == "own")
            return own;
        return busReq;
    endfunction

    task automatic waitFor(input string what, input int count);
        int n;
        n = 0;
        while (!condMet(what, count) && n < WAIT_LIMIT) begin
            @(negedge QnCPUCLK);
            n++;
        end
        if (!condMet(what, count)) begin
            errCount++;
            $display("%s: timed out waiting for %s", curTest, what);
        end
    endtask

    // Models start empty with every test
    task automatic applyReset();
        txQ.delete();
        rxQ.delete();
        wrAddrQ.delete();
        wrDataQ.delete();
        rxWant    = 0;
        holdGrant = 1'b0;
        @(posedge QnCPUCLK);
        rstN <= 1'b0;
        repeat (2) @(posedge QnCPUCLK);
        rstN <= 1'b1;
        @(negedge QnCPUCLK);
    endtask

    `include "resdmacTests.svh"

    initial begin : watchdog
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin : mainSeq
        int i;
        for (i = 0; i < 256; i++)
            memArr[i] = fillWord(i * 4);
        testResetRegs();
        testScsiToMem();
        testMemToScsi();
        testFlush();
        testInterrupt();
        testArbitration();
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+bench
rtl/sdmacRegPkg.sv
rtl/sdmacBusPkg.sv
rtl/dmaRegisters.sv
rtl/dmaFifo.sv
rtl/scsiPortSm.sv
rtl/cpuBusMaster.sv
rtl/resdmacTop.sv
bench/resdmacTb.sv
